// ==== project.f ====
lockstep_pkg.sv
core_out_if.sv
acc_core.sv
core_lockstep.sv
alert_collector.sv
lockstep_top.sv
tb_clk_gen.sv
tb_lockstep_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_lockstep_top \
  -f project.f

out=$(./obj_dir/Vtb_lockstep_top)
printf '%s\n' "$out"

# Pass only if the testbench printed its pass line
printf '%s\n' "$out" | grep -qx 'PASS: all tests'

// ==== tb_lockstep_top.sv ====
// Testbench for the lockstep accumulator with reference model and checking assertions
`timescale 1ns/1ps
`default_nettype none

module tb_lockstep_top import lockstep_pkg::*; ();

  localparam int unsigned DW        = DataWidthDefault;
  localparam int unsigned Offset    = LockstepOffsetDefault;
  // Edges from a shadow illegal command to the sampled minor alert
  localparam int unsigned ShadowLag = Offset + 2;

  logic          clk;
  logic          rst_n;
  logic          cmd_valid;
  logic [2:0]    cmd_code;
  op_e           cmd_op;
  logic [DW-1:0] cmd_operand;
  logic          selftest;
  logic          alert_clear;
  logic          result_valid;
  logic [DW-1:0] result;
  logic          alert_minor;
  logic          alert_major;

  logic          legal_strobe;
  logic          illegal_strobe;
  logic [DW-1:0] model_acc;
  logic [DW-1:0] exp_result;
  logic [31:0]   rng;
  int            check_errors;
  int            timeout_errors;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  lockstep_top #(
    .DataWidth     (DW),
    .LockstepOffset(Offset)
  ) lockstep_top_i (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .cmd_valid_i   (cmd_valid),
    .cmd_op_i      (cmd_op),
    .cmd_operand_i (cmd_operand),
    .selftest_i    (selftest),
    .alert_clear_i (alert_clear),
    .result_valid_o(result_valid),
    .result_o      (result),
    .alert_minor_o (alert_minor),
    .alert_major_o (alert_major)
  );

  // Codes 5 to 7 are outside the opcode set
  assign cmd_op         = op_e'(cmd_code);
  assign legal_strobe   = cmd_valid && (cmd_code <= 3'd4);
  assign illegal_strobe = cmd_valid && (cmd_code > 3'd4);

  //////////////////////////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [DW-1:0] apply_op(input logic [DW-1:0] acc,
                                             input logic [2:0]    code,
                                             input logic [DW-1:0] operand);
    logic [DW-1:0] acc_new;
    case (code)
      OP_LOAD: acc_new = operand;
      OP_ADD:  acc_new = acc + operand;
      OP_SUB:  acc_new = acc - operand;
      OP_XOR:  acc_new = acc ^ operand;
      OP_CLR:  acc_new = '0;
      default: acc_new = acc;
    endcase
    return acc_new;
  endfunction

  // Model value for the command sampled at the previous edge
  always @(posedge clk) begin
    exp_result <= model_acc;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic issue_cmd(input logic [2:0] code, input logic [DW-1:0] operand,
                           input logic clear);
    cmd_valid   = 1'b1;
    cmd_code    = code;
    cmd_operand = operand;
    alert_clear = clear;
    model_acc   = apply_op(model_acc, code, operand);
    next_cycle();
    cmd_valid   = 1'b0;
    alert_clear = 1'b0;
  endtask

  task automatic pulse_clear();
    alert_clear = 1'b1;
    next_cycle();
    alert_clear = 1'b0;
  endtask

  task automatic wait_reset_release(input int max_cycles);
    int n;
    n = 0;
    while (!rst_n && n < max_cycles) begin
      next_cycle();
      n++;
    end
    if (!rst_n) begin
      timeout_errors++;
      $display("Timeout: reset was not released within %0d cycles", max_cycles);
    end
  endtask

  task automatic wait_alert_level(input bit major, input bit level, input int max_cycles);
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < max_cycles) begin
      next_cycle();
      seen = major ? (alert_major == level) : (alert_minor == level);
      n++;
    end
    if (!seen) begin
      timeout_errors++;
      $display("Timeout: %s alert did not go to %0b within %0d cycles",
               major ? "major" : "minor", level, max_cycles);
    end
  endtask

  // Mixed legal and illegal commands with back-to-back strobes and clears
  task automatic random_traffic(input int n_cmds);
    logic [2:0]    code;
    logic [DW-1:0] operand;
    logic          clear;
    int            gap;
    for (int i = 0; i < n_cmds; i++) begin
      rng = xorshift32(rng);
      if (rng[6:3] < 4'd3) begin
        code = 3'd5 + 3'(rng[9:8] % 2'd3);
      end else begin
        code = 3'(rng[12:10] % 3'd5);
      end
      clear   = (rng[19:16] == 4'd0);
      gap     = int'(rng[22:21]);
      rng     = xorshift32(rng);
      operand = DW'(rng);
      issue_cmd(code, operand, clear);
      idle_cycles(gap);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  result_strobe_chk: assert property (
    @(posedge clk) disable iff (!rst_n)
    result_valid == $past(legal_strobe)
  ) else begin
    check_errors++;
    $display("ERR %0t: result_valid_o is %0b against the command strobes", $time, result_valid);
  end

  result_value_chk: assert property (
    @(posedge clk) disable iff (!rst_n)
    result_valid |-> (result == exp_result)
  ) else begin
    check_errors++;
    $display("ERR %0t: result_o is %h, expected %h", $time, result, exp_result);
  end

  // Main core sets it two edges on and the shadow core Offset edges later
  minor_alert_chk: assert property (
    @(posedge clk) disable iff (!rst_n)
    alert_minor == ($past(illegal_strobe, 2) || $past(illegal_strobe, ShadowLag) ||
                    ($past(alert_minor) && !$past(alert_clear)))
  ) else begin
    check_errors++;
    $display("ERR %0t: alert_minor_o is %0b against the illegal and clear history",
             $time, alert_minor);
  end

  major_alert_chk: assert property (
    @(posedge clk) disable iff (!rst_n)
    alert_major == ($past(alert_major) || $past(selftest, 2))
  ) else begin
    check_errors++;
    $display("ERR %0t: alert_major_o is %0b against the self-test history", $time, alert_major);
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    cmd_valid      = 1'b0;
    cmd_code       = 3'd0;
    cmd_operand    = '0;
    selftest       = 1'b0;
    alert_clear    = 1'b0;
    model_acc      = '0;
    rng            = 32'hd5c7_e433;
    check_errors   = 0;
    timeout_errors = 0;

    wait_reset_release(40);
    // Quiet period while the shadow leaves reset
    idle_cycles(12);

    // Directed run with an illegal opcode in the middle
    issue_cmd(OP_LOAD, DW'(32'h0000_0005), 1'b0);
    issue_cmd(OP_ADD, DW'(32'h0000_0003), 1'b0);
    issue_cmd(OP_SUB, DW'(32'h0000_000a), 1'b0);
    issue_cmd(3'd6, DW'(32'h1234_5678), 1'b0);
    issue_cmd(OP_XOR, DW'(32'hffff_0000), 1'b0);
    idle_cycles(1);
    issue_cmd(OP_CLR, DW'(32'h0000_0000), 1'b0);
    issue_cmd(OP_ADD, DW'(32'h0000_0007), 1'b0);
    wait_alert_level(1'b0, 1'b1, 8);
    idle_cycles(Offset + 3);
    pulse_clear();
    wait_alert_level(1'b0, 1'b0, 4);

    random_traffic(600);
    idle_cycles(Offset + 4);

    // Comparator self-test
    selftest = 1'b1;
    next_cycle();
    selftest = 1'b0;
    wait_alert_level(1'b1, 1'b1, 6);
    pulse_clear();
    random_traffic(150);
    idle_cycles(8);

    $display("Checks done: %0d check errors, %0d timeouts", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// Testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HalfPeriodNs = 50,
  parameter int ResetCycles  = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    // Release just after the edge
    #1;
    rst_no = 1'b1;
  end

  always #(HalfPeriodNs) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== lockstep_top.sv ====
// Top level with main core, lockstep checker and alert collector
`timescale 1ns/1ps
`default_nettype none

module lockstep_top import lockstep_pkg::*; #(
  parameter int unsigned DataWidth      = DataWidthDefault,
  parameter int unsigned LockstepOffset = LockstepOffsetDefault
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Command strobe
  input  logic                 cmd_valid_i,
  input  op_e                  cmd_op_i,
  input  logic [DataWidth-1:0] cmd_operand_i,

  input  logic                 selftest_i,
  input  logic                 alert_clear_i,

  output logic                 result_valid_o,
  output logic [DataWidth-1:0] result_o,
  output logic                 alert_minor_o,
  output logic                 alert_major_o
);

  logic mismatch;
  logic shadow_illegal;

  core_out_if #(.DataWidth(DataWidth)) main_out ();

  //////////////////////////////////////////////////////////////////////
  // Main core
  //////////////////////////////////////////////////////////////////////

  acc_core #(
    .DataWidth    (DataWidth)
  ) u_main_core (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_op_i     (cmd_op_i),
    .cmd_operand_i(cmd_operand_i),
    .out_o        (main_out)
  );

  assign result_valid_o = main_out.result_valid;
  assign result_o       = main_out.result;

  //////////////////////////////////////////////////////////////////////
  // Lockstep checker and alerts
  //////////////////////////////////////////////////////////////////////

  core_lockstep #(
    .DataWidth       (DataWidth),
    .LockstepOffset  (LockstepOffset)
  ) u_lockstep (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_op_i        (cmd_op_i),
    .cmd_operand_i   (cmd_operand_i),
    .main_i          (main_out),
    .selftest_i      (selftest_i),
    .mismatch_o      (mismatch),
    .shadow_illegal_o(shadow_illegal)
  );

  alert_collector #(
    .LockstepOffset  (LockstepOffset)
  ) u_alerts (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .main_illegal_i  (main_out.illegal),
    .shadow_illegal_i(shadow_illegal),
    .mismatch_i      (mismatch),
    .alert_clear_i   (alert_clear_i),
    .alert_minor_o   (alert_minor_o),
    .alert_major_o   (alert_major_o)
  );

endmodule

`default_nettype wire

// ==== alert_collector.sv ====
// Sticky minor and major alert registers for the lockstep pair
`timescale 1ns/1ps
`default_nettype none

module alert_collector import lockstep_pkg::*; #(
  parameter int unsigned LockstepOffset = LockstepOffsetDefault
) (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic main_illegal_i,
  input  logic shadow_illegal_i,
  input  logic mismatch_i,
  input  logic alert_clear_i,

  output logic alert_minor_o,
  output logic alert_major_o
);

  logic minor_set;
  logic minor_q;
  logic major_q;

  // Illegal opcode seen by either core
  assign minor_set = main_illegal_i | shadow_illegal_i;

  //////////////////////////////////////////////////////////////////////
  // Alert registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      minor_q <= 1'b0;
      major_q <= 1'b0;
    end else begin
      // New event wins over clear
      if (minor_set) begin
        minor_q <= 1'b1;
      end else if (alert_clear_i) begin
        minor_q <= 1'b0;
      end
      // Only reset drops the major alert
      if (mismatch_i) begin
        major_q <= 1'b1;
      end
    end
  end

  assign alert_minor_o = minor_q;
  assign alert_major_o = major_q;

  // Shadow trails the main core by the lockstep offset
  shadow_illegal_follows_main: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !mismatch_i |-> (shadow_illegal_i == $past(main_illegal_i, LockstepOffset))
  ) else $error("shadow illegal strobe out of step with main core");

endmodule

`default_nettype wire

// ==== core_lockstep.sv ====
// Lockstep checker with delayed shadow core, delay lines and output comparator
`timescale 1ns/1ps
`default_nettype none

module core_lockstep import lockstep_pkg::*; #(
  parameter int unsigned DataWidth      = DataWidthDefault,
  parameter int unsigned LockstepOffset = LockstepOffsetDefault
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 cmd_valid_i,
  input  op_e                  cmd_op_i,
  input  logic [DataWidth-1:0] cmd_operand_i,

  core_out_if.monitor          main_i,

  input  logic                 selftest_i,
  output logic                 mismatch_o,
  output logic                 shadow_illegal_o
);

  localparam int unsigned CntW = $clog2(LockstepOffset);

  if (LockstepOffset < 2) begin : gen_offset_check
    $fatal(1, "LockstepOffset must be at least 2");
  end

  //////////////////////////////////////////////////////////////////////
  // Shadow reset release
  //////////////////////////////////////////////////////////////////////

  logic [CntW-1:0] rst_cnt_q;
  logic            rst_done;
  logic            rst_shadow_nq;

  assign rst_done = (rst_cnt_q == CntW'(LockstepOffset - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_cnt_q     <= '0;
      rst_shadow_nq <= 1'b0;
    end else begin
      if (!rst_done) begin
        rst_cnt_q <= rst_cnt_q + CntW'(1);
      end
      rst_shadow_nq <= rst_done;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Command delay line
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    op_e                  op;
    logic [DataWidth-1:0] operand;
  } cmd_t;

  logic [LockstepOffset-1:0] cmd_valid_q;
  cmd_t [LockstepOffset-1:0] cmd_q;

  // Stage 0 feeds the shadow core
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_valid_q <= '0;
    end else begin
      cmd_valid_q <= {cmd_valid_i, cmd_valid_q[LockstepOffset-1:1]};
    end
  end

  always_ff @(posedge clk_i) begin
    for (int unsigned i = 0; i < LockstepOffset - 1; i++) begin
      cmd_q[i] <= cmd_q[i+1];
    end
    cmd_q[LockstepOffset-1] <= '{op: cmd_op_i, operand: cmd_operand_i};
  end

  //////////////////////////////////////////////////////////////////////
  // Main output delay line
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                 result_valid;
    logic [DataWidth-1:0] result;
    logic                 illegal;
    logic                 busy;
  } core_out_t;

  core_out_t [LockstepOffset-1:0] main_q;
  core_out_t                      main_now;
  core_out_t                      shadow_now;

  assign main_now = '{
    result_valid: main_i.result_valid,
    result:       main_i.result,
    illegal:      main_i.illegal,
    busy:         main_i.busy
  };

  always_ff @(posedge clk_i) begin
    for (int unsigned i = 0; i < LockstepOffset - 1; i++) begin
      main_q[i] <= main_q[i+1];
    end
    main_q[LockstepOffset-1] <= main_now;
  end

  //////////////////////////////////////////////////////////////////////
  // Shadow core
  //////////////////////////////////////////////////////////////////////

  core_out_if #(.DataWidth(DataWidth)) shadow_out ();

  acc_core #(
    .DataWidth    (DataWidth)
  ) u_shadow_core (
    .clk_i        (clk_i),
    .rst_ni       (rst_shadow_nq),
    .cmd_valid_i  (cmd_valid_q[0]),
    .cmd_op_i     (cmd_q[0].op),
    .cmd_operand_i(cmd_q[0].operand),
    .out_o        (shadow_out)
  );

  assign shadow_now = '{
    result_valid: shadow_out.result_valid,
    result:       shadow_out.result,
    illegal:      shadow_out.illegal,
    busy:         shadow_out.busy
  };

  //////////////////////////////////////////////////////////////////////
  // Comparator
  //////////////////////////////////////////////////////////////////////

  logic selftest_q;

  // Self-test goes through one stage to line up with the compare point
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      selftest_q <= 1'b0;
    end else begin
      selftest_q <= selftest_i;
    end
  end

  assign mismatch_o       = rst_shadow_nq & ((shadow_now != main_q[0]) | selftest_q);
  assign shadow_illegal_o = shadow_out.illegal;

endmodule

`default_nettype wire

// ==== acc_core.sv ====
// Accumulator core executing single-cycle command strobes
`timescale 1ns/1ps
`default_nettype none

module acc_core import lockstep_pkg::*; #(
  parameter int unsigned DataWidth = DataWidthDefault
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 cmd_valid_i,
  input  op_e                  cmd_op_i,
  input  logic [DataWidth-1:0] cmd_operand_i,

  core_out_if.source           out_o
);

  logic [DataWidth-1:0] acc_d, acc_q;
  logic                 result_valid_d, result_valid_q;
  logic                 illegal_d, illegal_q;

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    acc_d          = acc_q;
    result_valid_d = 1'b0;
    illegal_d      = 1'b0;

    if (cmd_valid_i) begin
      result_valid_d = 1'b1;
      case (cmd_op_i)
        OP_LOAD: acc_d = cmd_operand_i;
        OP_ADD:  acc_d = acc_q + cmd_operand_i;
        OP_SUB:  acc_d = acc_q - cmd_operand_i;
        OP_XOR:  acc_d = acc_q ^ cmd_operand_i;
        OP_CLR:  acc_d = '0;
        default: begin
          // Accumulator holds and no result follows
          result_valid_d = 1'b0;
          illegal_d      = 1'b1;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q          <= '0;
      result_valid_q <= 1'b0;
      illegal_q      <= 1'b0;
    end else begin
      acc_q          <= acc_d;
      result_valid_q <= result_valid_d;
      illegal_q      <= illegal_d;
    end
  end

  // Result is the accumulator after the last command
  assign out_o.result_valid = result_valid_q;
  assign out_o.result       = acc_q;
  assign out_o.illegal      = illegal_q;
  assign out_o.busy         = result_valid_q | illegal_q;

  // One command gives either a result or an illegal strobe
  result_xor_illegal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(out_o.result_valid && out_o.illegal)
  ) else $error("result_valid and illegal high together");

endmodule

`default_nettype wire

// ==== core_out_if.sv ====
// Interface for the observable outputs of one accumulator core
`timescale 1ns/1ps
`default_nettype none

interface core_out_if import lockstep_pkg::*; #(
  parameter int unsigned DataWidth = DataWidthDefault
) ();

  logic                 result_valid;
  logic [DataWidth-1:0] result;
  logic                 illegal;
  logic                 busy;

  // Driven by the core itself
  modport source (
    output result_valid,
    output result,
    output illegal,
    output busy
  );

  // Used by the lockstep checker and the top level
  modport monitor (
    input result_valid,
    input result,
    input illegal,
    input busy
  );

endinterface

`default_nettype wire

// ==== lockstep_pkg.sv ====
// Opcode enum and default data width and lockstep offset
`default_nettype none

package lockstep_pkg;

  //////////////////////////////////////////////////////////////////////
  // Defaults for the top level parameters
  //////////////////////////////////////////////////////////////////////

  // Accumulator and operand width
  parameter int unsigned DataWidthDefault = 32;

  // Delay of at least 2 cycles between the main and the shadow core
  parameter int unsigned LockstepOffsetDefault = 2;

  //////////////////////////////////////////////////////////////////////
  // Command opcodes
  //////////////////////////////////////////////////////////////////////

  // Codes 5 to 7 are not decoded and raise the illegal strobe
  typedef enum logic [2:0] {
    // Take the operand
    OP_LOAD = 3'd0,
    // Wrapping add
    OP_ADD  = 3'd1,
    // Wrapping subtract
    OP_SUB  = 3'd2,
    // Bitwise xor with the operand
    OP_XOR  = 3'd3,
    // Back to zero
    OP_CLR  = 3'd4
  } op_e;

endpackage

`default_nettype wire
